/* filelist.f */
hdl/stk_pkg.sv
hdl/stk_cmd_decode.sv
hdl/stk_pshpul_seq.sv
hdl/stk_mover.sv
hdl/stk_ram.sv
hdl/stk_engine_top.sv
verification/stk_engine_assert.sv
verification/stk_engine_tb.sv

/* hdl/stk_cmd_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command decoder, one command in flight at a time
// go pulses last one cen cycle, all state holds when cen is low
// unused opcode encodings are accepted and ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stk_cmd_decode (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              cmd_valid,
    input  stk_pkg::stk_op_e  cmd_op,
    input  logic [7:0]        cmd_postbyte,
    output logic              cmd_ready,
    input  logic              seq_busy,
    input  logic [7:0]        cc,
    output logic              psh_go,
    output logic              pul_go,
    output logic              us_sel_in,
    output logic              psh_pc,
    output logic              rti_cc,
    output logic              rti_other,
    output logic              psh_int,
    output logic [7:0]        postdata
);

    stk_pkg::stk_dec_state_e state;
    // set while the first (CC only) half of an rti is running
    logic rti_pend;
    logic go_pend;

    assign go_pend = psh_go || pul_go;

    // commands only land when both the decoder and the sequencer are free
    assign cmd_ready = (state == stk_pkg::dec_idle) && !seq_busy;

    // the command set has no PC-only push, jsr style calls stay in the cpu core
    assign psh_pc = 1'b0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= stk_pkg::dec_idle;
            psh_go    <= 1'b0;
            pul_go    <= 1'b0;
            us_sel_in <= 1'b0;
            rti_cc    <= 1'b0;
            rti_other <= 1'b0;
            psh_int   <= 1'b0;
            rti_pend  <= 1'b0;
            postdata  <= 8'h00;
        end else if (cen) begin
            case (state)
                stk_pkg::dec_idle: begin
                    if (cmd_valid && cmd_ready) begin
                        state    <= stk_pkg::dec_run;
                        postdata <= cmd_postbyte;
                        case (cmd_op)
                            stk_pkg::op_pshs: begin
                                psh_go    <= 1'b1;
                                us_sel_in <= 1'b0;
                            end
                            stk_pkg::op_pshu: begin
                                psh_go    <= 1'b1;
                                us_sel_in <= 1'b1;
                            end
                            stk_pkg::op_puls: begin
                                pul_go    <= 1'b1;
                                us_sel_in <= 1'b0;
                            end
                            stk_pkg::op_pulu: begin
                                pul_go    <= 1'b1;
                                us_sel_in <= 1'b1;
                            end
                            // interrupt frame always goes onto S
                            stk_pkg::op_swi: begin
                                psh_go    <= 1'b1;
                                psh_int   <= 1'b1;
                                us_sel_in <= 1'b0;
                            end
                            // rti starts by pulling CC alone from S
                            stk_pkg::op_rti: begin
                                pul_go    <= 1'b1;
                                rti_cc    <= 1'b1;
                                rti_pend  <= 1'b1;
                                us_sel_in <= 1'b0;
                            end
                            default: state <= stk_pkg::dec_idle;
                        endcase
                    end
                end
                stk_pkg::dec_run: begin
                    if (go_pend) begin
                        // the sequencer loads its mask on this edge
                        psh_go    <= 1'b0;
                        pul_go    <= 1'b0;
                        rti_cc    <= 1'b0;
                        rti_other <= 1'b0;
                        psh_int   <= 1'b0;
                    end else if (!seq_busy) begin
                        state <= rti_pend ? stk_pkg::dec_rti_wait : stk_pkg::dec_idle;
                    end
                end
                stk_pkg::dec_rti_wait: begin
                    // pulled CC is in the register file by now, the
                    // sequencer reads its E flag when the mask loads
                    pul_go    <= 1'b1;
                    rti_other <= 1'b1;
                    rti_pend  <= 1'b0;
                    state     <= stk_pkg::dec_run;
                end
                default: state <= stk_pkg::dec_idle;
            endcase
        end
    end

endmodule

/* hdl/stk_engine_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stack push/pull engine, decoder, sequencer, mover and RAM
// a command lands when cen, cmd_valid and cmd_ready are high
// ADDR_W sets the stack RAM depth, at most 16
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stk_engine_top #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              cmd_valid,
    input  stk_pkg::stk_op_e  cmd_op,
    input  logic [7:0]        cmd_postbyte,
    output logic              cmd_ready,
    input  logic              reg_wr,
    input  stk_pkg::stk_reg_e reg_sel,
    input  logic [15:0]       reg_wdata,
    output logic [15:0]       reg_rdata,
    output logic              busy
);

    // decoder to sequencer
    logic              psh_go, pul_go, us_sel_in, psh_pc;
    logic              rti_cc, rti_other, psh_int;
    logic [7:0]        postdata;
    // sequencer and mover handshake
    logic [7:0]        psh_sel, psh_bit, cc;
    logic              hi_lon, pul_en, pshdec, us_sel;
    // mover to stack RAM
    logic [ADDR_W-1:0] mem_addr;
    logic              mem_we;
    logic [7:0]        mem_wdata, mem_rdata;

    stk_cmd_decode i_stk_cmd_decode (
        .clk          (clk),
        .rst          (rst),
        .cen          (cen),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_postbyte (cmd_postbyte),
        .cmd_ready    (cmd_ready),
        .seq_busy     (busy),
        .cc           (cc),
        .psh_go       (psh_go),
        .pul_go       (pul_go),
        .us_sel_in    (us_sel_in),
        .psh_pc       (psh_pc),
        .rti_cc       (rti_cc),
        .rti_other    (rti_other),
        .psh_int      (psh_int),
        .postdata     (postdata)
    );

    stk_pshpul_seq i_stk_pshpul_seq (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .postdata  (postdata),
        .cc        (cc),
        .psh_bit   (psh_bit),
        .psh_go    (psh_go),
        .pul_go    (pul_go),
        .us_sel_in (us_sel_in),
        .psh_pc    (psh_pc),
        .rti_cc    (rti_cc),
        .rti_other (rti_other),
        .psh_int   (psh_int),
        .psh_sel   (psh_sel),
        .hi_lon    (hi_lon),
        .pul_en    (pul_en),
        .pshdec    (pshdec),
        .us_sel    (us_sel),
        .busy      (busy)
    );

    stk_mover #(
        .ADDR_W (ADDR_W)
    ) i_stk_mover (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .psh_sel   (psh_sel),
        .hi_lon    (hi_lon),
        .pul_en    (pul_en),
        .pshdec    (pshdec),
        .us_sel    (us_sel),
        .busy      (busy),
        .psh_bit   (psh_bit),
        .cc        (cc),
        .reg_wr    (reg_wr),
        .reg_sel   (reg_sel),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    stk_ram #(
        .ADDR_W (ADDR_W)
    ) i_stk_ram (
        .clk   (clk),
        .addr  (mem_addr),
        .we    (mem_we),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

/* hdl/stk_mover.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file and byte mover between registers and stack
// ADDR_W must not exceed 16, upper pointer bits are dropped
// reg_wr wins over engine moves, write only while idle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stk_mover #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic [7:0]        psh_sel,
    input  logic              hi_lon,
    input  logic              pul_en,
    input  logic              pshdec,
    input  logic              us_sel,
    input  logic              busy,
    output logic [7:0]        psh_bit,
    output logic [7:0]        cc,
    input  logic              reg_wr,
    input  stk_pkg::stk_reg_e reg_sel,
    input  logic [15:0]       reg_wdata,
    output logic [15:0]       reg_rdata,
    output logic [ADDR_W-1:0] mem_addr,
    output logic              mem_we,
    output logic [7:0]        mem_wdata,
    input  logic [7:0]        mem_rdata
);

    logic [7:0]  a, b, dp;
    logic [15:0] x, y, u, s, pc;
    logic [15:0] act_ptr, oth_ptr, sel_val, stk_addr;
    logic        sel_16, byte_hi, step, cap;

    function automatic logic [15:0] put_byte(
        input logic [15:0] r,
        input logic        hi,
        input logic [7:0]  d
    );
        put_byte = hi ? {d, r[7:0]} : {r[15:8], d};
    endfunction

    // pushes go high bit first (PC), pulls low bit first (CC)
    always_comb begin
        psh_bit = 8'h00;
        if (pshdec) begin
            for (int i = 0; i < 8; i++) begin
                if (psh_sel[i]) psh_bit = 8'(1 << i);
            end
        end else begin
            psh_bit = psh_sel & (~psh_sel + 8'd1);
        end
    end

    // bit 6 names whichever pointer is not doing the stacking
    assign act_ptr = us_sel ? u : s;
    assign oth_ptr = us_sel ? s : u;

    always_comb begin
        case (psh_bit)
            8'h80:   sel_val = pc;
            8'h40:   sel_val = oth_ptr;
            8'h20:   sel_val = y;
            8'h10:   sel_val = x;
            8'h08:   sel_val = {8'h00, dp};
            8'h04:   sel_val = {8'h00, b};
            8'h02:   sel_val = {8'h00, a};
            8'h01:   sel_val = {8'h00, cc};
            default: sel_val = 16'h0000;
        endcase
    end

    // a push stores the low byte first so the high byte sits lower in memory,
    // a pull therefore meets the high byte first
    assign sel_16  = psh_bit[7:4] != 4'h0;
    assign byte_hi = sel_16 && (hi_lon ^ pshdec);

    assign step = cen && busy && pshdec;
    assign cap  = cen && busy && pul_en && !pshdec;

    // pre-decrement on push, post-increment on pull
    assign stk_addr  = pshdec ? act_ptr - 16'd1 : act_ptr;
    assign mem_addr  = stk_addr[ADDR_W-1:0];
    assign mem_we    = step;
    assign mem_wdata = byte_hi ? sel_val[15:8] : sel_val[7:0];

    // flags and stack pointers start cleared
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cc <= 8'h00;
            s  <= 16'h0000;
            u  <= 16'h0000;
        end else if (reg_wr) begin
            case (reg_sel)
                stk_pkg::reg_cc: cc <= reg_wdata[7:0];
                stk_pkg::reg_s:  s  <= reg_wdata;
                stk_pkg::reg_u:  u  <= reg_wdata;
                default: ;
            endcase
        end else begin
            if (step) begin
                if (us_sel) u <= u - 16'd1;
                else s <= s - 16'd1;
            end
            if (cap) begin
                if (psh_bit[0]) cc <= mem_rdata;
                if (us_sel) begin
                    u <= u + 16'd1;
                    if (psh_bit[6]) s <= put_byte(s, byte_hi, mem_rdata);
                end else begin
                    s <= s + 16'd1;
                    if (psh_bit[6]) u <= put_byte(u, byte_hi, mem_rdata);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reg_wr) begin
            case (reg_sel)
                stk_pkg::reg_a:  a  <= reg_wdata[7:0];
                stk_pkg::reg_b:  b  <= reg_wdata[7:0];
                stk_pkg::reg_dp: dp <= reg_wdata[7:0];
                stk_pkg::reg_x:  x  <= reg_wdata;
                stk_pkg::reg_y:  y  <= reg_wdata;
                stk_pkg::reg_pc: pc <= reg_wdata;
                default: ;
            endcase
        end else if (cap) begin
            if (psh_bit[1]) a  <= mem_rdata;
            if (psh_bit[2]) b  <= mem_rdata;
            if (psh_bit[3]) dp <= mem_rdata;
            if (psh_bit[4]) x  <= put_byte(x, byte_hi, mem_rdata);
            if (psh_bit[5]) y  <= put_byte(y, byte_hi, mem_rdata);
            if (psh_bit[7]) pc <= put_byte(pc, byte_hi, mem_rdata);
        end
    end

    always_comb begin
        case (reg_sel)
            stk_pkg::reg_cc: reg_rdata = {8'h00, cc};
            stk_pkg::reg_a:  reg_rdata = {8'h00, a};
            stk_pkg::reg_b:  reg_rdata = {8'h00, b};
            stk_pkg::reg_dp: reg_rdata = {8'h00, dp};
            stk_pkg::reg_x:  reg_rdata = x;
            stk_pkg::reg_y:  reg_rdata = y;
            stk_pkg::reg_u:  reg_rdata = u;
            stk_pkg::reg_s:  reg_rdata = s;
            stk_pkg::reg_pc: reg_rdata = pc;
            default:         reg_rdata = 16'h0000;
        endcase
    end

endmodule

/* hdl/stk_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the stack push/pull engine
// register select codes map to one 16-bit word each
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package stk_pkg;

    // command opcodes accepted on the cmd_* port
    typedef enum logic [2:0] {
        op_pshs = 3'd0,
        op_pshu = 3'd1,
        op_puls = 3'd2,
        op_pulu = 3'd3,
        op_swi  = 3'd4,
        op_rti  = 3'd5
    } stk_op_e;

    // decoder states, rti is the only command that visits dec_rti_wait
    typedef enum logic [1:0] {
        dec_idle     = 2'd0,
        dec_run      = 2'd1,
        dec_rti_wait = 2'd2
    } stk_dec_state_e;

    // register selects for the load/read port
    // 8-bit registers read back with a zero upper byte
    typedef enum logic [3:0] {
        reg_cc = 4'd0,
        reg_a  = 4'd1,
        reg_b  = 4'd2,
        reg_dp = 4'd3,
        reg_x  = 4'd4,
        reg_y  = 4'd5,
        reg_u  = 4'd6,
        reg_s  = 4'd7,
        reg_pc = 4'd8
    } stk_reg_e;

    // entire-state flag in CC, picks the full or short interrupt frame
    localparam int CC_E = 7;

endpackage

/* hdl/stk_pshpul_seq.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register mask sequencer, one byte per cen step
// a pulled byte takes two steps because the stack RAM
// has a registered read; an empty mask never raises busy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stk_pshpul_seq (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [7:0] postdata,
    input  logic [7:0] cc,
    input  logic [7:0] psh_bit,
    input  logic       psh_go,
    input  logic       pul_go,
    input  logic       us_sel_in,
    input  logic       psh_pc,
    input  logic       rti_cc,
    input  logic       rti_other,
    input  logic       psh_int,
    output logic [7:0] psh_sel,
    output logic       hi_lon,
    output logic       pul_en,
    output logic       pshdec,
    output logic       us_sel,
    output logic       busy
);

    logic [7:0] mask;

    assign busy = psh_sel != 8'h00;

    // effective postbyte, the special cases override the command byte
    always_comb begin
        if (rti_cc) begin
            mask = 8'h01;
        end else if (psh_pc) begin
            mask = 8'h80;
        end else if (rti_other) begin
            // everything but CC, or PC alone for a short frame
            mask = cc[stk_pkg::CC_E] ? 8'hfe : 8'h80;
        end else if (psh_int) begin
            mask = cc[stk_pkg::CC_E] ? 8'hff : 8'h81;
        end else begin
            mask = postdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            psh_sel <= 8'h00;
            hi_lon  <= 1'b0;
            pul_en  <= 1'b0;
            pshdec  <= 1'b0;
            us_sel  <= 1'b0;
        end else if (cen) begin
            if (!busy) begin
                pul_en <= 1'b0;
                pshdec <= psh_go;
                if (psh_go || pul_go) begin
                    psh_sel <= mask;
                    us_sel  <= us_sel_in;
                    hi_lon  <= 1'b1;
                end
            end else if (!pshdec && !pul_en) begin
                // read phase, the address is out and RAM data lands next edge
                pul_en <= 1'b1;
            end else begin
                pul_en <= 1'b0;
                if (psh_bit[7:4] != 4'h0 && hi_lon) begin
                    // first half of a 16-bit register, the bit stays set
                    hi_lon <= 1'b0;
                end else begin
                    hi_lon  <= 1'b1;
                    psh_sel <= psh_sel & ~psh_bit;
                end
            end
        end
    end

endmodule

/* hdl/stk_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-port stack RAM, read data one clock late
// contents are undefined until written
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stk_ram #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    input  logic              we,
    input  logic [7:0]        wdata,
    output logic [7:0]        rdata
);

    logic [7:0] mem [2**ADDR_W];

    // read runs on every clock, so data stays put while the address holds
    always_ff @(posedge clk) begin
        if (we) mem[addr] <= wdata;
        rdata <= mem[addr];
    end

endmodule

/* verification/stk_engine_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequencer checks, bound into every stk_pshpul_seq
// fail_cnt counts failed assertions for the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stk_engine_assert (
    input logic       clk,
    input logic       rst,
    input logic [7:0] psh_sel,
    input logic       busy,
    input logic       pshdec,
    input logic       psh_go,
    input logic       pul_go
);

    int fail_cnt = 0;

    // a running mask only ever loses bits
    mask_shrinks: assert property (@(posedge clk) disable iff (rst)
        busy |=> (psh_sel & ~$past(psh_sel)) == 8'h00)
        else begin
            $error("psh_sel gained bits while busy");
            fail_cnt++;
        end

    // direction is fixed for the whole run
    dir_stable: assert property (@(posedge clk) disable iff (rst)
        busy |=> $stable(pshdec))
        else begin
            $error("pshdec changed while busy");
            fail_cnt++;
        end

    no_go_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !(psh_go || pul_go))
        else begin
            $error("go pulse arrived while the sequencer was busy");
            fail_cnt++;
        end

endmodule

bind stk_pshpul_seq stk_engine_assert i_stk_engine_assert (
    .clk     (clk),
    .rst     (rst),
    .psh_sel (psh_sel),
    .busy    (busy),
    .pshdec  (pshdec),
    .psh_go  (psh_go),
    .pul_go  (pul_go)
);

/* verification/stk_engine_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the stack push/pull engine with ADDR_W = 8
// the whole stack RAM is filled through pushes before any pull
// registers are only written while the engine is idle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stk_engine_tb;

    localparam int ADDR_W     = 8;
    localparam int WAIT_LIMIT = 2000;

    logic              clk = 1'b0;
    logic              rst;
    logic              cen = 1'b1;
    logic              cmd_valid;
    stk_pkg::stk_op_e  cmd_op;
    logic [7:0]        cmd_postbyte;
    logic              cmd_ready;
    logic              reg_wr;
    stk_pkg::stk_reg_e reg_sel;
    logic [15:0]       reg_wdata;
    logic [15:0]       reg_rdata;
    logic              busy;

    logic              gap_en = 1'b0;
    logic [31:0]       lfsr_q = 32'hf898_5560;
    logic [31:0]       cen_lfsr = 32'hf898_5560;
    logic              cen_drop;

    // reference register file indexed by the stk_reg_e code
    logic [15:0]       m_reg [9];
    logic [7:0]        m_mem [2**ADDR_W];

    int checks = 0;
    int errors = 0;
    int test_no = 0;
    int failed_tests = 0;
    int err_mark = 0;

    always #20 clk = ~clk;

    stk_engine_top #(
        .ADDR_W (ADDR_W)
    ) i_stk_engine_top (
        .clk          (clk),
        .rst          (rst),
        .cen          (cen),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_postbyte (cmd_postbyte),
        .cmd_ready    (cmd_ready),
        .reg_wr       (reg_wr),
        .reg_sel      (reg_sel),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .busy         (busy)
    );

    // feedback polynomial x^32 + x^22 + x^2 + x + 1 and the new bit is the one taken
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // cen drops for roughly one cycle in four while gaps are enabled
    always @(posedge clk) begin
        if (gap_en) begin
            cen_lfsr = lfsr_step(cen_lfsr);
            cen_drop = cen_lfsr[0];
            cen_lfsr = lfsr_step(cen_lfsr);
            cen <= !(cen_drop && cen_lfsr[0]);
        end else begin
            cen <= 1'b1;
        end
    end

    // bytes moved for a mask where bits 7 to 4 are 16-bit registers
    function automatic int frame_bytes(input logic [7:0] mask);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) n += (i >= 4) ? 2 : 1;
        end
        return n;
    endfunction

    // maps a postbyte bit to a register code and bit 6 to the pointer not stacking
    function automatic int reg_of_bit(input int i, input logic us);
        if (i == 7) return 8;
        if (i == 6) return us ? 7 : 6;
        return i;
    endfunction

    // PC goes first and the low byte of a word lands above its high byte
    function automatic void model_push(input logic us, input logic [7:0] mask);
        int          p;
        int          r;
        logic [15:0] ptr;
        p   = us ? 6 : 7;
        ptr = m_reg[p];
        for (int i = 7; i >= 0; i--) begin
            if (mask[i]) begin
                r   = reg_of_bit(i, us);
                ptr = ptr - 16'd1;
                m_mem[ptr[ADDR_W-1:0]] = m_reg[r][7:0];
                if (i >= 4) begin
                    ptr = ptr - 16'd1;
                    m_mem[ptr[ADDR_W-1:0]] = m_reg[r][15:8];
                end
            end
        end
        m_reg[p] = ptr;
    endfunction

    // CC comes off first and words arrive high byte first
    function automatic void model_pull(input logic us, input logic [7:0] mask);
        int          p;
        int          r;
        logic [15:0] ptr;
        logic [15:0] val;
        p   = us ? 6 : 7;
        ptr = m_reg[p];
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) begin
                r = reg_of_bit(i, us);
                if (i >= 4) begin
                    val[15:8] = m_mem[ptr[ADDR_W-1:0]];
                    ptr = ptr + 16'd1;
                    val[7:0] = m_mem[ptr[ADDR_W-1:0]];
                end else begin
                    val = {8'h00, m_mem[ptr[ADDR_W-1:0]]};
                end
                ptr = ptr + 16'd1;
                m_reg[r] = val;
            end
        end
        m_reg[p] = ptr;
    endfunction

    function automatic void model_cmd(input stk_pkg::stk_op_e op, input logic [7:0] pb);
        case (op)
            stk_pkg::op_pshs: model_push(1'b0, pb);
            stk_pkg::op_pshu: model_push(1'b1, pb);
            stk_pkg::op_puls: model_pull(1'b0, pb);
            stk_pkg::op_pulu: model_pull(1'b1, pb);
            stk_pkg::op_swi:  model_push(1'b0, m_reg[0][stk_pkg::CC_E] ? 8'hff : 8'h81);
            stk_pkg::op_rti: begin
                model_pull(1'b0, 8'h01);
                // the E flag of the CC just pulled picks the frame size
                model_pull(1'b0, m_reg[0][stk_pkg::CC_E] ? 8'hfe : 8'h80);
            end
            default: ;
        endcase
    endfunction

    // enabled clocks with busy high, one per pushed byte and two per pulled byte
    // because each pull spends a step on the RAM read
    // the model CC is read after the command has been applied to the model
    function automatic int busy_steps(input stk_pkg::stk_op_e op, input logic [7:0] pb);
        case (op)
            stk_pkg::op_pshs, stk_pkg::op_pshu: return frame_bytes(pb);
            stk_pkg::op_puls, stk_pkg::op_pulu: return 2 * frame_bytes(pb);
            stk_pkg::op_swi:
                return frame_bytes(m_reg[0][stk_pkg::CC_E] ? 8'hff : 8'h81);
            stk_pkg::op_rti:
                return 2 + 2 * frame_bytes(m_reg[0][stk_pkg::CC_E] ? 8'hfe : 8'h80);
            default: return 0;
        endcase
    endfunction

    task automatic fail_timeout(input string what);
        $display("timeout at %0t ns, %s", $time, what);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // the write lands on the second rising edge
    task automatic write_reg(input stk_pkg::stk_reg_e r, input logic [15:0] v);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_sel   <= r;
        reg_wdata <= v;
        @(posedge clk);
        reg_wr    <= 1'b0;
        m_reg[r] = (int'(r) < 4) ? {8'h00, v[7:0]} : v;
    endtask

    task automatic read_reg(input stk_pkg::stk_reg_e r, output logic [15:0] v);
        @(posedge clk);
        reg_sel <= r;
        @(negedge clk);
        v = reg_rdata;
    endtask

    // S is left alone and U is loaded only when asked for
    task automatic load_random(input logic with_u);
        write_reg(stk_pkg::reg_cc, 16'(rand_bits(8)));
        write_reg(stk_pkg::reg_a, 16'(rand_bits(8)));
        write_reg(stk_pkg::reg_b, 16'(rand_bits(8)));
        write_reg(stk_pkg::reg_dp, 16'(rand_bits(8)));
        write_reg(stk_pkg::reg_x, 16'(rand_bits(16)));
        write_reg(stk_pkg::reg_y, 16'(rand_bits(16)));
        write_reg(stk_pkg::reg_pc, 16'(rand_bits(16)));
        if (with_u) write_reg(stk_pkg::reg_u, 16'(rand_bits(16)));
    endtask

    task automatic run_cmd(input stk_pkg::stk_op_e op, input logic [7:0] pb);
        int n;
        int steps;
        int exp_steps;
        @(posedge clk);
        cmd_valid    <= 1'b1;
        cmd_op       <= op;
        cmd_postbyte <= pb;
        // values at the falling edge are the ones the next rising edge sees
        n = 0;
        @(negedge clk);
        while (!(cen && cmd_ready)) begin
            n++;
            if (n > WAIT_LIMIT) fail_timeout("the engine never accepted a command");
            @(negedge clk);
        end
        @(posedge clk);
        cmd_valid <= 1'b0;
        n = 0;
        steps = 0;
        @(negedge clk);
        while (!cmd_ready) begin
            if (busy && cen) steps++;
            n++;
            if (n > WAIT_LIMIT) fail_timeout("cmd_ready did not come back after a command");
            @(negedge clk);
        end
        model_cmd(op, pb);
        exp_steps = busy_steps(op, pb);
        checks++;
        if (steps != exp_steps) begin
            errors++;
            $display("Fail t=%0t: %s kept busy for %0d cen steps, expected %0d",
                     $time, op.name(), steps, exp_steps);
        end
    endtask

    task automatic compare_regs(input string tag, input logic [15:0] exp [9]);
        stk_pkg::stk_reg_e rs;
        for (int r = 0; r < 9; r++) begin
            rs = stk_pkg::stk_reg_e'(r);
            @(posedge clk);
            reg_sel <= rs;
            @(negedge clk);
            checks++;
            if (reg_rdata !== exp[r]) begin
                errors++;
                $display("Fail t=%0t: %s, %s reads %h, expected %h",
                         $time, tag, rs.name(), reg_rdata, exp[r]);
            end
        end
    endtask

    task automatic start_test();
        test_no++;
        err_mark = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            $display("test %0d %s: ok", test_no, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_no, name, errors - err_mark);
        end
    endtask

    initial begin
        logic [15:0]      snap [9];
        logic [15:0]      scr [9];
        logic [15:0]      expv [9];
        logic [15:0]      s_now;
        logic [7:0]       pb;
        logic [2:0]       op_bits;
        stk_pkg::stk_op_e op;

        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd_op       = stk_pkg::op_pshs;
        cmd_postbyte = 8'h00;
        reg_wr       = 1'b0;
        reg_sel      = stk_pkg::reg_cc;
        reg_wdata    = 16'h0000;
        for (int r = 0; r < 9; r++) m_reg[r] = 16'h0000;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // 21 full frames and one 4-byte frame cover all 256 stack bytes
        write_reg(stk_pkg::reg_s, 16'h0000);
        for (int k = 0; k < 22; k++) begin
            load_random(1'b1);
            run_cmd(stk_pkg::op_pshs, (k < 21) ? 8'hff : 8'h0f);
        end
        compare_regs("preload", m_reg);

        start_test();
        load_random(1'b0);
        write_reg(stk_pkg::reg_s, 16'h00c0);
        write_reg(stk_pkg::reg_u, 16'h0060);
        pb   = 8'(rand_bits(8));
        snap = m_reg;
        run_cmd(stk_pkg::op_pshs, pb);
        read_reg(stk_pkg::reg_s, s_now);
        checks++;
        if (s_now !== 16'(snap[7] - frame_bytes(pb))) begin
            errors++;
            $display("Fail t=%0t: pshs %h left S at %h, started at %h",
                     $time, pb, s_now, snap[7]);
        end
        compare_regs("pshs", m_reg);
        run_cmd(stk_pkg::op_puls, pb);
        compare_regs("puls restore", snap);
        end_test("push then pull on S");

        // A, B and X go onto U and come back as CC, A, B and DP
        start_test();
        snap = m_reg;
        run_cmd(stk_pkg::op_pshu, 8'h16);
        compare_regs("pshu", m_reg);
        run_cmd(stk_pkg::op_pulu, 8'h0f);
        compare_regs("pulu cross", m_reg);
        read_reg(stk_pkg::reg_dp, s_now);
        checks++;
        if (s_now !== {8'h00, snap[4][7:0]}) begin
            errors++;
            $display("Fail t=%0t: DP reads %h, X low byte was %h", $time, s_now, snap[4][7:0]);
        end
        end_test("cross pull on U");

        for (int e = 1; e >= 0; e--) begin
            start_test();
            load_random(1'b0);
            write_reg(stk_pkg::reg_cc, {8'h00, e[0], 7'(rand_bits(7))});
            snap = m_reg;
            run_cmd(stk_pkg::op_swi, 8'h00);
            read_reg(stk_pkg::reg_s, s_now);
            checks++;
            if (s_now !== 16'(snap[7] - (e ? 12 : 3))) begin
                errors++;
                $display("Fail t=%0t: swi with E=%0d moved S from %h to %h",
                         $time, e, snap[7], s_now);
            end
            compare_regs("swi", m_reg);
            // scramble everything but S so the restore is visible
            load_random(1'b1);
            scr = m_reg;
            run_cmd(stk_pkg::op_rti, 8'h00);
            if (e != 0) begin
                expv = snap;
            end else begin
                expv = scr;
            end
            expv[0] = snap[0];
            expv[7] = snap[7];
            expv[8] = snap[8];
            compare_regs("rti", expv);
            end_test(e ? "swi and rti, E set" : "swi and rti, E clear");
        end

        start_test();
        @(posedge clk);
        gap_en <= 1'b1;
        for (int k = 0; k < 40; k++) begin
            op_bits = 3'(rand_bits(3) % 6);
            op      = stk_pkg::stk_op_e'(op_bits);
            pb      = 8'(rand_bits(8));
            run_cmd(op, pb);
            compare_regs(op.name(), m_reg);
        end
        @(posedge clk);
        gap_en <= 1'b0;
        end_test("random commands with cen gaps");

        errors += i_stk_engine_top.i_stk_pshpul_seq.i_stk_engine_assert.fail_cnt;
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_no, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
